// File: bb_sram_defines.svh
// Sizes the whole design; BB_BYTE_AW must equal log2(BB_SW) and only BB_DW of 32 is supported
`ifndef BB_SRAM_DEFINES_SVH
`define BB_SRAM_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////////////////////

// Data word on the bus and in the RAM
`define BB_DW 32

// Byte address width seen by the bus master
`define BB_AW 32

// Byte lanes per word
`define BB_SW (`BB_DW / 8)

// Byte-in-word field of a byte address
// Kept in step with BB_SW by hand
`define BB_BYTE_AW 2

////////////////////////////////////////////////////////////////////////////
// RAM geometry
////////////////////////////////////////////////////////////////////////////

// Word address width of the RAM, 1024 words
// Bus address bits above this are dropped, so addresses wrap
`define SRAM_AW 10

`endif

// File: bb_bus_pkg.sv
// Bus-side types only; widths come from the defines header and the address is little endian
`include "bb_sram_defines.svh"

package bb_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data and byte select
  ////////////////////////////////////////////////////////////////////////////

  // One bus data word
  typedef logic [`BB_DW-1:0] bb_data_t;

  // Byte select, one bit per lane
  // Bit 0 covers data bits 7:0
  typedef logic [`BB_SW-1:0] bb_sel_t;

  ////////////////////////////////////////////////////////////////////////////
  // Address views
  ////////////////////////////////////////////////////////////////////////////

  /*
   * +--------------------+--------------+
   * |    word address    | byte in word |
   * +--------------------+--------------+
   *  BB_AW-BB_BYTE_AW       BB_BYTE_AW
   */

  // Word and byte fields of a byte address
  typedef struct packed {
    logic [`BB_AW-`BB_BYTE_AW-1:0] word;
    logic [`BB_BYTE_AW-1:0]        byte_sel;
  } bb_addr_fields_t;

  // Same bus address seen flat or split into fields
  // The master writes the flat view
  // The bridge decodes through the field view
  typedef union packed {
    logic [`BB_AW-1:0] flat;
    bb_addr_fields_t   fields;
  } bb_addr_u;

endpackage

// File: sram_pkg.sv
// RAM-side types only; the RAM is word addressed and sized by SRAM_AW in the defines header
`include "bb_sram_defines.svh"

package sram_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Generic RAM port types
  ////////////////////////////////////////////////////////////////////////////

  // Stored word
  // Same width as the bus data word
  typedef logic [`BB_DW-1:0] sram_word_t;

  // Word address into the array
  // No byte bits here, the bridge strips them
  typedef logic [`SRAM_AW-1:0] sram_addr_t;

  // Per-lane write mask
  // Bit n enables data bits 8n+7 down to 8n
  typedef logic [`BB_SW-1:0] sram_sel_t;

endpackage

// File: bb_sram_bridge.sv
// Master must keep bb_en_i low in reset and select a lane on writes; no waits, no error response
`timescale 1ns/1ps
`include "bb_sram_defines.svh"

module bb_sram_bridge (
  // Clock and reset
  input  logic                 bb_clk_i,
  input  logic                 bb_rst_i,

  // Blackbone bus side
  input  logic                 bb_en_i,
  input  logic                 bb_we_i,
  input  logic                 bb_burst_i,
  input  bb_bus_pkg::bb_sel_t  bb_sel_i,
  input  bb_bus_pkg::bb_addr_u bb_addr_i,
  input  bb_bus_pkg::bb_data_t bb_din_i,
  output bb_bus_pkg::bb_data_t bb_dout_o,

  // Generic RAM port
  output logic                 ram_ce_o,
  output logic                 ram_we_o,
  output sram_pkg::sram_addr_t ram_addr_o,
  output sram_pkg::sram_word_t ram_din_o,
  output sram_pkg::sram_sel_t  ram_sel_o,
  input  sram_pkg::sram_word_t ram_dout_i
);

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  // Word address taken from the bus, upper bits dropped
  sram_pkg::sram_addr_t bus_word_addr;

  // Word address of the most recent access
  sram_pkg::sram_addr_t last_addr_q;

  // Any access seen since reset
  logic                 addr_vld_q;

  // Next word for a burst beat
  sram_pkg::sram_addr_t burst_addr;

  // Address actually sent to the RAM this cycle
  sram_pkg::sram_addr_t word_addr;

  ////////////////////////////////////////////////////////////////////////////
  // Address generation
  ////////////////////////////////////////////////////////////////////////////

  // Byte field is ignored, access is always a whole word with lane masks
  assign bus_word_addr = bb_addr_i.fields.word[`SRAM_AW-1:0];

  // Burst steps one word past the last access
  // Before any access the burst starts at word 0
  always_comb begin
    if (addr_vld_q) begin
      burst_addr = last_addr_q + 1'b1;
    end else begin
      burst_addr = '0;
    end
  end

  // Bus address is don't care during a burst
  assign word_addr = bb_burst_i ? burst_addr : bus_word_addr;

  // Remember last word address, held across idle cycles
  always_ff @(posedge bb_clk_i) begin
    if (bb_rst_i) begin
      last_addr_q <= '0;
      addr_vld_q  <= 1'b0;
    end else if (bb_en_i) begin
      last_addr_q <= word_addr;
      addr_vld_q  <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // RAM strobes and data
  ////////////////////////////////////////////////////////////////////////////

  // Every enabled cycle is one RAM access
  assign ram_ce_o   = bb_en_i;
  assign ram_we_o   = bb_en_i & bb_we_i;
  assign ram_addr_o = word_addr;
  assign ram_din_o  = bb_din_i;

  // Lanes only on writes
  assign ram_sel_o  = (bb_en_i && bb_we_i) ? bb_sel_i : '0;

  // RAM output is already registered, one cycle read latency
  assign bb_dout_o  = ram_dout_i;

  ////////////////////////////////////////////////////////////////////////////
  // Bus protocol checks
  ////////////////////////////////////////////////////////////////////////////

  // A write with no lane would be a silent no-op
  a_wr_has_lane : assert property (
    @(posedge bb_clk_i) disable iff (bb_rst_i)
    (bb_en_i && bb_we_i) |-> (bb_sel_i != '0)
  ) else $error("bus write with no byte lane selected");

  // Burst only makes sense on an enabled cycle
  a_burst_with_en : assert property (
    @(posedge bb_clk_i) disable iff (bb_rst_i)
    bb_burst_i |-> bb_en_i
  ) else $error("bb_burst_i high without bb_en_i");

endmodule

// File: sram_sp.sv
// Single port, one access per cycle; array contents are undefined until written
`timescale 1ns/1ps
`include "bb_sram_defines.svh"

module sram_sp (
  // Clock and reset
  input  logic                 bb_clk_i,
  input  logic                 bb_rst_i,

  // RAM port
  input  logic                 ram_ce_i,
  input  logic                 ram_we_i,
  input  sram_pkg::sram_addr_t ram_addr_i,
  input  sram_pkg::sram_word_t ram_din_i,
  input  sram_pkg::sram_sel_t  ram_sel_i,
  output sram_pkg::sram_word_t ram_dout_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  // 1024 words, no reset on the array
  sram_pkg::sram_word_t mem [0:(1 << `SRAM_AW)-1];

  // Registered read data
  sram_pkg::sram_word_t rd_data_q;

  ////////////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////////////

  // Each lane written on its own enable
  always_ff @(posedge bb_clk_i) begin
    if (ram_ce_i && ram_we_i) begin
      for (int i = 0; i < `BB_SW; i++) begin
        if (ram_sel_i[i]) begin
          mem[ram_addr_i][i*8 +: 8] <= ram_din_i[i*8 +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////////////////////

  // Loads only on enabled reads
  // Holds across writes and idle cycles
  always_ff @(posedge bb_clk_i) begin
    if (bb_rst_i) begin
      rd_data_q <= '0;
    end else if (ram_ce_i && !ram_we_i) begin
      rd_data_q <= mem[ram_addr_i];
    end
  end

  assign ram_dout_o = rd_data_q;

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // X on the address would corrupt or read an unknown word
  a_addr_known : assert property (
    @(posedge bb_clk_i) disable iff (bb_rst_i)
    ram_ce_i |-> !$isunknown(ram_addr_i)
  ) else $error("unknown RAM address with ram_ce_i high");

endmodule

// File: bb_sram_top.sv
// Blackbone bus to 1024-word SRAM; reads return one cycle later and addresses wrap at 4 KiB
`timescale 1ns/1ps

module bb_sram_top (
  // Clock and reset
  input  logic                 bb_clk_i,
  input  logic                 bb_rst_i,

  // Blackbone bus
  input  logic                 bb_en_i,
  input  logic                 bb_we_i,
  input  logic                 bb_burst_i,
  input  bb_bus_pkg::bb_sel_t  bb_sel_i,
  input  bb_bus_pkg::bb_addr_u bb_addr_i,
  input  bb_bus_pkg::bb_data_t bb_din_i,
  output bb_bus_pkg::bb_data_t bb_dout_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Bridge to RAM wires
  ////////////////////////////////////////////////////////////////////////////

  logic                 ram_ce;
  logic                 ram_we;
  sram_pkg::sram_addr_t ram_addr;
  sram_pkg::sram_word_t ram_din;
  sram_pkg::sram_sel_t  ram_sel;
  sram_pkg::sram_word_t ram_dout;

  ////////////////////////////////////////////////////////////////////////////
  // Instances
  ////////////////////////////////////////////////////////////////////////////

  // Bus decode and burst addressing
  bb_sram_bridge u_bridge (
    .bb_clk_i   (bb_clk_i),
    .bb_rst_i   (bb_rst_i),
    .bb_en_i    (bb_en_i),
    .bb_we_i    (bb_we_i),
    .bb_burst_i (bb_burst_i),
    .bb_sel_i   (bb_sel_i),
    .bb_addr_i  (bb_addr_i),
    .bb_din_i   (bb_din_i),
    .bb_dout_o  (bb_dout_o),
    .ram_ce_o   (ram_ce),
    .ram_we_o   (ram_we),
    .ram_addr_o (ram_addr),
    .ram_din_o  (ram_din),
    .ram_sel_o  (ram_sel),
    .ram_dout_i (ram_dout)
  );

  // Byte-lane RAM
  sram_sp u_sram (
    .bb_clk_i   (bb_clk_i),
    .bb_rst_i   (bb_rst_i),
    .ram_ce_i   (ram_ce),
    .ram_we_i   (ram_we),
    .ram_addr_i (ram_addr),
    .ram_din_i  (ram_din),
    .ram_sel_i  (ram_sel),
    .ram_dout_o (ram_dout)
  );

endmodule

// File: tb_bb_sram_top.sv
// Single master only; every word is written before it is read, so the model never sees X data
`timescale 1ns/1ps
`include "bb_sram_defines.svh"

module tb_bb_sram_top;

  ////////////////////////////////////////////////////////////////////////////
  // Run length and limits
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned SEED      = 32'hcc29523d;
  localparam int          MEM_WORDS = 1 << `SRAM_AW;
  localparam int          FIRST_N   = 2;
  localparam int          PRE_READS = 8;
  localparam int          WR_RD_N   = 96;
  localparam int          LANE_N    = 96;
  localparam int          BURST_N   = 40;
  localparam int          MAX_BURST = 8;
  localparam int          ALIAS_N   = 32;
  localparam int          MIX_N     = 2000;

  // Upper bound on driven cycles, bursts counted at full length
  localparam int STIM_CYCLES = 3 + 1 + FIRST_N + MEM_WORDS + PRE_READS + 2 * WR_RD_N +
                               2 * LANE_N + BURST_N * (2 * MAX_BURST + 1) + ALIAS_N * 5 +
                               MIX_N + 2;
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;

  ////////////////////////////////////////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////////////////////////////////////////

  logic                 bb_clk_i;
  logic                 bb_rst_i;
  logic                 bb_en_i;
  logic                 bb_we_i;
  logic                 bb_burst_i;
  bb_bus_pkg::bb_sel_t  bb_sel_i;
  bb_bus_pkg::bb_addr_u bb_addr_i;
  bb_bus_pkg::bb_data_t bb_din_i;
  bb_bus_pkg::bb_data_t bb_dout_o;

  ////////////////////////////////////////////////////////////////////////////
  // Model state
  ////////////////////////////////////////////////////////////////////////////

  // Shadow memory
  bb_bus_pkg::bb_data_t model_mem [0:MEM_WORDS-1];

  // Word address of the last access, for bursts
  sram_pkg::sram_addr_t shadow_addr;
  logic                 shadow_vld;

  // Value bb_dout_o must hold outside reads
  bb_bus_pkg::bb_data_t last_read;

  int reads_checked;
  int cycle_cnt = 0;

  bb_sram_top DUT (
    .bb_clk_i   (bb_clk_i),
    .bb_rst_i   (bb_rst_i),
    .bb_en_i    (bb_en_i),
    .bb_we_i    (bb_we_i),
    .bb_burst_i (bb_burst_i),
    .bb_sel_i   (bb_sel_i),
    .bb_addr_i  (bb_addr_i),
    .bb_din_i   (bb_din_i),
    .bb_dout_o  (bb_dout_o)
  );

  // 8 ns clock
  initial begin
    bb_clk_i = 1'b0;
    forever #4 bb_clk_i = ~bb_clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Failure and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_on_error(input string why);
    $display("*** TEST FAILED ***");
    $fatal(1, "%s", why);
  endtask

  // Read result one cycle after the access
  task automatic check_data(input bb_bus_pkg::bb_data_t exp, input bb_bus_pkg::bb_data_t act,
                            input sram_pkg::sram_addr_t word);
    reads_checked = reads_checked + 1;
    if (act !== exp) begin
      $display("[FAIL] %0t ns: read of word %0d expected %h got %h", $time, word, exp, act);
      stop_on_error("read data mismatch");
    end
  endtask

  // Output must not move on idle or write cycles
  task automatic check_idle_hold(input bb_bus_pkg::bb_data_t exp,
                                 input bb_bus_pkg::bb_data_t act);
    if (act !== exp) begin
      $display("[FAIL] %0t ns: held output expected %h got %h", $time, exp, act);
      stop_on_error("output did not hold");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus driver with model update
  ////////////////////////////////////////////////////////////////////////////

  // Byte address of a word, high and byte bits zero
  function automatic logic [`BB_AW-1:0] word_to_byte(input sram_pkg::sram_addr_t w);
    bb_bus_pkg::bb_addr_u dec;
    dec.flat = '0;
    dec.fields.word[`SRAM_AW-1:0] = w;
    return dec.flat;
  endfunction

  // One bus cycle, entered 1 ns after a rising edge
  task automatic drive_cycle(input logic en, input logic we, input logic burst,
                             input bb_bus_pkg::bb_sel_t sel, input logic [`BB_AW-1:0] addr,
                             input bb_bus_pkg::bb_data_t din);
    bb_bus_pkg::bb_addr_u dec;
    sram_pkg::sram_addr_t wa;
    bb_bus_pkg::bb_data_t exp;
    logic                 rd;
    int                   i;
    dec.flat   = addr;
    rd         = en && !we;
    wa         = '0;
    exp        = last_read;
    bb_en_i    = en;
    bb_we_i    = we;
    bb_burst_i = burst;
    bb_sel_i   = sel;
    bb_addr_i  = dec;
    bb_din_i   = din;
    if (en) begin
      // Burst continues one word on, wraps at the top
      if (burst) begin
        wa = shadow_vld ? shadow_addr + 1'b1 : '0;
      end else begin
        wa = dec.fields.word[`SRAM_AW-1:0];
      end
      shadow_addr = wa;
      shadow_vld  = 1'b1;
      if (we) begin
        for (i = 0; i < `BB_SW; i++) begin
          if (sel[i]) begin
            model_mem[wa][i*8 +: 8] = din[i*8 +: 8];
          end
        end
      end else begin
        exp = model_mem[wa];
      end
    end
    @(posedge bb_clk_i);
    #1;
    if (rd) begin
      check_data(exp, bb_dout_o, wa);
      last_read = exp;
    end else begin
      check_idle_hold(last_read, bb_dout_o);
    end
  endtask

  task automatic write_word(input logic [`BB_AW-1:0] addr, input bb_bus_pkg::bb_sel_t sel,
                            input bb_bus_pkg::bb_data_t din);
    drive_cycle(1'b1, 1'b1, 1'b0, sel, addr, din);
  endtask

  task automatic read_word(input logic [`BB_AW-1:0] addr);
    drive_cycle(1'b1, 1'b0, 1'b0, '0, addr, $urandom());
  endtask

  task automatic idle_cycle();
    drive_cycle(1'b0, 1'b0, 1'b0, '0, $urandom(), $urandom());
  endtask

  // First beat carries the address, later beats drive junk on bb_addr_i
  task automatic run_burst(input sram_pkg::sram_addr_t start, input int len,
                           input logic is_write);
    int b;
    drive_cycle(1'b1, is_write, 1'b0, '1, word_to_byte(start), $urandom());
    for (b = 1; b < len; b++) begin
      drive_cycle(1'b1, is_write, 1'b1, '1, $urandom(), $urandom());
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Timeout
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge bb_clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not end within %0d clock cycles", TIMEOUT_CYCLES);
      stop_on_error("timeout");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    sram_pkg::sram_addr_t wr_q [$];
    sram_pkg::sram_addr_t w;
    bb_bus_pkg::bb_addr_u alias_a;
    int                   n;
    int                   len;
    logic                 is_wr;
    logic                 en;
    logic                 we;
    logic                 burst;
    bb_bus_pkg::bb_sel_t  sel;

    void'($urandom(SEED));
    reads_checked = 0;
    shadow_addr   = '0;
    shadow_vld    = 1'b0;
    last_read     = '0;
    bb_rst_i      = 1'b1;
    bb_en_i       = 1'b0;
    bb_we_i       = 1'b0;
    bb_burst_i    = 1'b0;
    bb_sel_i      = '0;
    bb_addr_i     = '0;
    bb_din_i      = '0;

    // Reset for 3 cycles, output must come up zero
    repeat (3) @(posedge bb_clk_i);
    #1;
    bb_rst_i = 1'b0;
    check_idle_hold('0, bb_dout_o);

    // Burst with no earlier access lands on word 0
    drive_cycle(1'b1, 1'b1, 1'b1, '1, $urandom(), $urandom());
    read_word(word_to_byte('0));

    // Fill every word with all lanes
    for (n = 0; n < MEM_WORDS; n++) begin
      write_word(word_to_byte(sram_pkg::sram_addr_t'(n)), '1, $urandom());
    end
    for (n = 0; n < PRE_READS; n++) begin
      read_word(word_to_byte(sram_pkg::sram_addr_t'($urandom_range(0, MEM_WORDS - 1))));
    end

    // Full-word writes, then read back
    for (n = 0; n < WR_RD_N; n++) begin
      w = sram_pkg::sram_addr_t'($urandom_range(0, MEM_WORDS - 1));
      wr_q.push_back(w);
      write_word(word_to_byte(w), '1, $urandom());
    end
    while (wr_q.size() > 0) begin
      read_word(word_to_byte(wr_q.pop_front()));
    end

    // Partial lane masks
    for (n = 0; n < LANE_N; n++) begin
      w = sram_pkg::sram_addr_t'($urandom_range(0, MEM_WORDS - 1));
      write_word(word_to_byte(w), bb_bus_pkg::bb_sel_t'($urandom_range(1, 14)), $urandom());
      read_word(word_to_byte(w));
    end

    // Bursts, half of them start near the top to wrap
    for (n = 0; n < BURST_N; n++) begin
      if ($urandom_range(0, 1) == 1) begin
        w = sram_pkg::sram_addr_t'(MEM_WORDS - 8 + $urandom_range(0, 7));
      end else begin
        w = sram_pkg::sram_addr_t'($urandom_range(0, MEM_WORDS - 1));
      end
      len   = $urandom_range(2, MAX_BURST);
      is_wr = ($urandom_range(0, 1) == 1);
      run_burst(w, len, is_wr);
      if (is_wr) begin
        run_burst(w, len, 1'b0);
      end
      idle_cycle();
    end

    // High address bits alias onto the low word
    for (n = 0; n < ALIAS_N; n++) begin
      w = sram_pkg::sram_addr_t'($urandom_range(0, MEM_WORDS - 1));
      alias_a.flat = $urandom();
      alias_a.fields.word[`SRAM_AW-1:0] = w;
      alias_a.flat[`BB_AW-1] = 1'b1;
      write_word(alias_a.flat, '1, $urandom());
      read_word(word_to_byte(w));
      alias_a.flat[`BB_AW-2:`SRAM_AW+`BB_BYTE_AW] = ~alias_a.flat[`BB_AW-2:`SRAM_AW+`BB_BYTE_AW];
      read_word(alias_a.flat);
      // Output holds across idle and write
      idle_cycle();
      write_word(word_to_byte(w + 1'b1), '1, $urandom());
    end

    // Mixed random traffic
    for (n = 0; n < MIX_N; n++) begin
      en    = ($urandom_range(0, 3) != 0);
      we    = ($urandom_range(0, 1) == 1);
      burst = en && ($urandom_range(0, 2) == 0);
      sel   = we ? bb_bus_pkg::bb_sel_t'($urandom_range(1, 15))
                 : bb_bus_pkg::bb_sel_t'($urandom_range(0, 15));
      drive_cycle(en, we, burst, sel, $urandom(), $urandom());
    end
    idle_cycle();

    $display("Checked %0d reads", reads_checked);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: project.f
+incdir+.
bb_bus_pkg.sv
sram_pkg.sv
bb_sram_bridge.sv
sram_sp.sv
bb_sram_top.sv
tb_bb_sram_top.sv

// File: Makefile
# Verilator build and run for the Blackbone SRAM subsystem

VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_bb_sram_top
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := *** TEST FAILED ***
PASS_MSG  := *** TEST PASSED ***

SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean build

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The run may stop with a nonzero status, the log decides the result
test: build
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
